/* logic/memory_bus_pkg.sv */
package memory_bus_pkg;

   // Bus data and address widths
   typedef logic [31:0] word_t;
   typedef logic [29:0] word_addr_t;   // Byte address without the two low bits
   typedef logic [31:0] byte_addr_t;
   typedef logic [3:0]  byte_mask_t;   // One write enable per byte lane

   // Access types issued by the core
   typedef enum logic [3:0] {
      LOAD_BYTE,
      LOAD_HALF,
      LOAD_WORD,
      LOAD_BYTE_U,
      LOAD_HALF_U,
      STORE_BYTE,
      STORE_HALF,
      STORE_WORD,
      MEM_NONE
   } mem_inst_type_t;

   // Address map defaults, overridable from the top level
   localparam int         DEFAULT_MEM_ADDR_W = 12;
   localparam word_addr_t DEFAULT_DATA_BASE  = 30'h0;

   // UART window is fixed by the map
   localparam word_addr_t UART_BASE  = 30'h100;
   localparam int         UART_WORDS = 4;

endpackage

/* logic/memory_bus_if.sv */
`timescale 1ns/1ps

interface memory_bus_if
   import memory_bus_pkg::*;
();

   word_addr_t address;
   logic       write_enable;   // Level, sampled at the rising edge
   logic       read;
   byte_mask_t mask_byte;
   word_t      write_data;
   word_t      read_data;      // Valid in the same cycle as the address

   modport master (
      output address,
      output write_enable,
      output read,
      output mask_byte,
      output write_data,
      input  read_data
   );

   modport slave (
      input  address,
      input  write_enable,
      input  read,
      input  mask_byte,
      input  write_data,
      output read_data
   );

endinterface

/* logic/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit
   import memory_bus_pkg::*;
(
   input  mem_inst_type_t inst_type_i,
   input  byte_addr_t     address_i,
   input  word_t          write_data_i,
   output word_t          read_data_o,
   output logic           exception_o,
   memory_bus_if.master   bus
);

   logic [1:0] offset;
   logic       is_load;
   logic       is_store;
   logic       is_half;
   logic       is_word;
   logic       is_unsigned;
   logic       misaligned;
   byte_mask_t base_mask;
   word_t      lane_data;

   assign offset = address_i[1:0];

   // Access type decode
   always_comb begin
      is_load     = 1'b0;
      is_store    = 1'b0;
      is_half     = 1'b0;
      is_word     = 1'b0;
      is_unsigned = 1'b0;
      unique case (inst_type_i)
         LOAD_BYTE:   is_load = 1'b1;
         LOAD_BYTE_U: begin
            is_load     = 1'b1;
            is_unsigned = 1'b1;
         end
         LOAD_HALF: begin
            is_load = 1'b1;
            is_half = 1'b1;
         end
         LOAD_HALF_U: begin
            is_load     = 1'b1;
            is_half     = 1'b1;
            is_unsigned = 1'b1;
         end
         LOAD_WORD: begin
            is_load = 1'b1;
            is_word = 1'b1;
         end
         STORE_BYTE:  is_store = 1'b1;
         STORE_HALF: begin
            is_store = 1'b1;
            is_half  = 1'b1;
         end
         STORE_WORD: begin
            is_store = 1'b1;
            is_word  = 1'b1;
         end
         default: ;   // MEM_NONE
      endcase
   end

   assign misaligned  = (is_half && offset[0]) || (is_word && (offset != 2'd0));
   assign exception_o = misaligned;

   assign base_mask = is_word ? 4'b1111 : (is_half ? 4'b0011 : 4'b0001);

   // No strobe at all on a misaligned access
   assign bus.address      = address_i[31:2];
   assign bus.read         = is_load && !misaligned;
   assign bus.write_enable = is_store && !misaligned;
   assign bus.mask_byte    = (is_load || is_store) && !misaligned ? base_mask << offset : '0;
   assign bus.write_data   = write_data_i << {offset, 3'b000};

   // Addressed lane moved down to bit 0
   assign lane_data = bus.read_data >> {offset, 3'b000};

   always_comb begin
      if (!bus.read) begin
         read_data_o = '0;
      end else if (is_word) begin
         read_data_o = lane_data;
      end else if (is_half) begin
         read_data_o = is_unsigned ? {16'h0, lane_data[15:0]}
                                   : {{16{lane_data[15]}}, lane_data[15:0]};
      end else begin
         read_data_o = is_unsigned ? {24'h0, lane_data[7:0]}
                                   : {{24{lane_data[7]}}, lane_data[7:0]};
      end
   end

endmodule

/* logic/bus_control.sv */
`timescale 1ns/1ps

module bus_control
   import memory_bus_pkg::*;
#(
   parameter int         MEM_ADDR_W = DEFAULT_MEM_ADDR_W,
   parameter word_addr_t DATA_BASE  = DEFAULT_DATA_BASE
) (
   input  logic        clk,   // Sampling clock for bound checks
   input  logic        reset_i,

   input  logic        probe_mem_i,
   input  word_addr_t  probe_address_i,
   input  logic        probe_mem_read_i,
   input  logic        probe_mem_write_i,
   input  byte_mask_t  probe_mask_byte_i,
   input  word_t       probe_write_data_i,
   output word_t       probe_read_data_o,

   memory_bus_if.slave  cpu,
   memory_bus_if.master mem,
   memory_bus_if.master uart,

   output logic        invalid_address_o
);

   localparam int MEM_WORDS = 2**MEM_ADDR_W;

   localparam logic [30:0] MEM_LO  = 31'(DATA_BASE);
   localparam logic [30:0] MEM_HI  = 31'(DATA_BASE) + 31'(MEM_WORDS);
   localparam logic [30:0] UART_LO = 31'(UART_BASE);
   localparam logic [30:0] UART_HI = 31'(UART_BASE) + 31'(UART_WORDS);

   word_addr_t  active_address;
   logic        active_write;
   logic        active_read;
   byte_mask_t  active_mask;
   word_t       active_data;
   logic [30:0] wide_address;
   logic        mem_in_range;
   logic        uart_hit;
   logic        mem_hit;
   word_t       slave_result;

   // Master select, probe has priority
   assign active_address = probe_mem_i ? probe_address_i    : cpu.address;
   assign active_write   = probe_mem_i ? probe_mem_write_i  : cpu.write_enable;
   assign active_read    = probe_mem_i ? probe_mem_read_i   : cpu.read;
   assign active_mask    = probe_mem_i ? probe_mask_byte_i  : cpu.mask_byte;
   assign active_data    = probe_mem_i ? probe_write_data_i : cpu.write_data;

   // Window decode; one extra bit keeps the upper bounds from wrapping
   assign wide_address = {1'b0, active_address};
   assign mem_in_range = (wide_address >= MEM_LO) && (wide_address < MEM_HI);
   assign uart_hit     = (wide_address >= UART_LO) && (wide_address < UART_HI);
   assign mem_hit      = mem_in_range && !uart_hit;   // UART overrides an overlapping RAM window

   assign invalid_address_o = (active_read || active_write) && !mem_hit && !uart_hit;

   // Data memory side
   assign mem.address      = active_address - DATA_BASE;
   assign mem.write_enable = active_write && mem_hit && !reset_i;
   assign mem.read         = active_read && mem_hit;
   assign mem.mask_byte    = active_mask;
   assign mem.write_data   = active_data;

   // UART side
   assign uart.address      = active_address - UART_BASE;
   assign uart.write_enable = active_write && uart_hit && !reset_i;
   assign uart.read         = active_read && uart_hit;
   assign uart.mask_byte    = active_mask;
   assign uart.write_data   = active_data;

   always_comb begin
      if (mem_hit) begin
         slave_result = mem.read_data;
      end else if (uart_hit) begin
         slave_result = uart.read_data;
      end else begin
         slave_result = '0;   // Invalid address reads as zero
      end
   end

   // Idle master sees zero
   assign probe_read_data_o = probe_mem_i ? slave_result : '0;
   assign cpu.read_data     = probe_mem_i ? '0 : slave_result;

endmodule

/* logic/data_memory.sv */
`timescale 1ns/1ps

module data_memory
   import memory_bus_pkg::*;
#(
   parameter int MEM_ADDR_W = DEFAULT_MEM_ADDR_W
) (
   input  logic        clk,
   memory_bus_if.slave bus
);

   localparam int MEM_WORDS = 2**MEM_ADDR_W;

   word_t                 ram [MEM_WORDS];
   logic [MEM_ADDR_W-1:0] index;

   // Window offset already applied upstream
   assign index = bus.address[MEM_ADDR_W-1:0];

   // Byte lane writes
   always_ff @(posedge clk) begin
      if (bus.write_enable) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (bus.mask_byte[lane]) begin
               ram[index][8*lane +: 8] <= bus.write_data[8*lane +: 8];
            end
         end
      end
   end

   assign bus.read_data = bus.read ? ram[index] : '0;   // Combinational read

endmodule

/* logic/uart_port.sv */
`timescale 1ns/1ps

module uart_port
   import memory_bus_pkg::*;
(
   input  logic        clk,
   input  logic        reset_i,
   memory_bus_if.slave bus,
   output logic [7:0]  uart_data_o,
   output logic        uart_write_o
);

   logic [7:0]  last_byte;
   logic [15:0] write_count;

   // Byte goes out in the same cycle as the accepted write
   assign uart_write_o = bus.write_enable;
   assign uart_data_o  = bus.write_data[7:0];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         last_byte   <= '0;
         write_count <= '0;
      end else if (bus.write_enable) begin
         last_byte   <= bus.write_data[7:0];
         write_count <= write_count + 16'd1;
      end
   end

   // Status readback
   always_comb begin
      bus.read_data = '0;
      if (bus.read) begin
         unique case (bus.address[1:0])
            2'd0:    bus.read_data = {24'h0, last_byte};
            2'd1:    bus.read_data = {16'h0, write_count};
            default: bus.read_data = '0;
         endcase
      end
   end

endmodule

/* logic/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top
   import memory_bus_pkg::*;
#(
   parameter int         MEM_ADDR_W = DEFAULT_MEM_ADDR_W,
   parameter word_addr_t DATA_BASE  = DEFAULT_DATA_BASE
) (
   input  logic           clk,
   input  logic           reset_i,

   // Debug probe
   input  logic           probe_mem_i,
   input  word_addr_t     probe_address_i,
   input  logic           probe_mem_read_i,
   input  logic           probe_mem_write_i,
   input  byte_mask_t     probe_mask_byte_i,
   input  word_t          probe_write_data_i,
   output word_t          probe_read_data_o,

   // Core data port
   input  mem_inst_type_t cpu_inst_type_i,
   input  byte_addr_t     cpu_address_i,
   input  word_t          cpu_write_data_i,
   output word_t          cpu_read_data_o,
   output logic           cpu_exception_o,

   output logic           invalid_address_o,
   output logic [7:0]     uart_data_o,
   output logic           uart_write_o
);

   memory_bus_if cpu_bus();
   memory_bus_if mem_bus();
   memory_bus_if uart_bus();

   load_store_unit u_load_store_unit (
      .inst_type_i  (cpu_inst_type_i),
      .address_i    (cpu_address_i),
      .write_data_i (cpu_write_data_i),
      .read_data_o  (cpu_read_data_o),
      .exception_o  (cpu_exception_o),
      .bus          (cpu_bus.master)
   );

   bus_control #(
      .MEM_ADDR_W (MEM_ADDR_W),
      .DATA_BASE  (DATA_BASE)
   ) u_bus_control (
      .clk                (clk),
      .reset_i            (reset_i),
      .probe_mem_i        (probe_mem_i),
      .probe_address_i    (probe_address_i),
      .probe_mem_read_i   (probe_mem_read_i),
      .probe_mem_write_i  (probe_mem_write_i),
      .probe_mask_byte_i  (probe_mask_byte_i),
      .probe_write_data_i (probe_write_data_i),
      .probe_read_data_o  (probe_read_data_o),
      .cpu                (cpu_bus.slave),
      .mem                (mem_bus.master),
      .uart               (uart_bus.master),
      .invalid_address_o  (invalid_address_o)
   );

   data_memory #(
      .MEM_ADDR_W (MEM_ADDR_W)
   ) u_data_memory (
      .clk (clk),
      .bus (mem_bus.slave)
   );

   uart_port u_uart_port (
      .clk          (clk),
      .reset_i      (reset_i),
      .bus          (uart_bus.slave),
      .uart_data_o  (uart_data_o),
      .uart_write_o (uart_write_o)
   );

endmodule

/* dv/mem_subsystem_assertions.sv */
`timescale 1ns/1ps

module mem_subsystem_assertions (
   input logic clk,
   input logic reset_i,
   input logic mem_write_i,
   input logic uart_write_i,
   input logic invalid_address_i
);

   int unsigned failures = 0;   // Assertion failures so far

   // Only one slave is written in a cycle
   write_exclusive: assert property (@(posedge clk) !(mem_write_i && uart_write_i))
      else begin
         failures++;
         $error("memory and UART write enables are high together");
      end

   no_write_in_reset: assert property (@(posedge clk) reset_i |-> !(mem_write_i || uart_write_i))
      else begin
         failures++;
         $error("write enable is high during reset");
      end

   // Invalid address must never reach a slave
   no_write_invalid: assert property (@(posedge clk)
      invalid_address_i |-> !(mem_write_i || uart_write_i))
      else begin
         failures++;
         $error("write enable is high with an invalid address");
      end

endmodule

bind bus_control mem_subsystem_assertions u_assertions (
   .clk               (clk),
   .reset_i           (reset_i),
   .mem_write_i       (mem.write_enable),
   .uart_write_i      (uart.write_enable),
   .invalid_address_i (invalid_address_o)
);

/* dv/mem_subsystem_tb.sv */
`timescale 1ns/1ps

module mem_subsystem_tb;
   import memory_bus_pkg::*;

   // Small RAM window above the UART so the base offset is exercised
   localparam int         MEM_ADDR_W = 8;
   localparam word_addr_t DATA_BASE  = 30'h200;
   localparam int         MEM_WORDS  = 2**MEM_ADDR_W;
   localparam int         NUM_OPS    = 800;

   logic           clk;
   logic           reset_i;
   logic           probe_mem_i;
   word_addr_t     probe_address_i;
   logic           probe_mem_read_i;
   logic           probe_mem_write_i;
   byte_mask_t     probe_mask_byte_i;
   word_t          probe_write_data_i;
   word_t          probe_read_data_o;
   mem_inst_type_t cpu_inst_type_i;
   byte_addr_t     cpu_address_i;
   word_t          cpu_write_data_i;
   word_t          cpu_read_data_o;
   logic           cpu_exception_o;
   logic           invalid_address_o;
   logic [7:0]     uart_data_o;
   logic           uart_write_o;

   word_t          model_mem [MEM_WORDS];
   byte_mask_t     model_valid [MEM_WORDS];   // Lanes written so far
   logic [7:0]     model_last_byte;
   logic [15:0]    model_count;
   integer         seed = 32'h5337;

   mem_subsystem_top #(
      .MEM_ADDR_W (MEM_ADDR_W),
      .DATA_BASE  (DATA_BASE)
   ) mem_subsystem_top_inst (
      .clk                (clk),
      .reset_i            (reset_i),
      .probe_mem_i        (probe_mem_i),
      .probe_address_i    (probe_address_i),
      .probe_mem_read_i   (probe_mem_read_i),
      .probe_mem_write_i  (probe_mem_write_i),
      .probe_mask_byte_i  (probe_mask_byte_i),
      .probe_write_data_i (probe_write_data_i),
      .probe_read_data_o  (probe_read_data_o),
      .cpu_inst_type_i    (cpu_inst_type_i),
      .cpu_address_i      (cpu_address_i),
      .cpu_write_data_i   (cpu_write_data_i),
      .cpu_read_data_o    (cpu_read_data_o),
      .cpu_exception_o    (cpu_exception_o),
      .invalid_address_o  (invalid_address_o),
      .uart_data_o        (uart_data_o),
      .uart_write_o       (uart_write_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      reset_i = 1'b1;
      repeat (10) @(posedge clk);
      #1 reset_i = 1'b0;
   end

   task automatic report_failure();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input word_t actual, input word_t expected, input string what);
      assert (actual === expected) else begin
         $display("error: time %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         report_failure();
      end
   endtask

   function automatic logic in_mem(input word_addr_t a);
      return (a >= DATA_BASE) && (a < DATA_BASE + MEM_WORDS);
   endfunction

   function automatic logic in_uart(input word_addr_t a);
      return (a >= UART_BASE) && (a < UART_BASE + 4);
   endfunction

   function automatic logic readable(input word_addr_t a);
      return !in_mem(a) || (model_valid[a - DATA_BASE] == 4'hF);
   endfunction

   // Word the bus should return at an address
   function automatic word_t model_read(input word_addr_t a);
      word_t result;
      result = '0;
      if (in_mem(a)) begin
         result = model_mem[a - DATA_BASE];
      end else if (in_uart(a) && a[1:0] == 2'd0) begin
         result = {24'h0, model_last_byte};
      end else if (in_uart(a) && a[1:0] == 2'd1) begin
         result = {16'h0, model_count};
      end
      return result;
   endfunction

   task automatic model_write(input word_addr_t a, input byte_mask_t mask, input word_t data);
      int idx;
      if (in_mem(a)) begin
         idx = a - DATA_BASE;
         for (int lane = 0; lane < 4; lane++) begin
            if (mask[lane]) begin
               model_mem[idx][8*lane +: 8] = data[8*lane +: 8];
            end
         end
         model_valid[idx] = model_valid[idx] | mask;
      end else if (in_uart(a)) begin
         model_last_byte = data[7:0];   // UART takes every write, mask ignored
         model_count     = model_count + 16'd1;
      end
   endtask

   function automatic word_addr_t rand_address();
      int pick;
      pick = $random(seed) & 7;
      if (pick < 4) begin
         return DATA_BASE + word_addr_t'($random(seed) & 31);   // Dense RAM region
      end else if (pick == 4) begin
         return DATA_BASE + word_addr_t'($random(seed) & 'hFF);
      end else if (pick == 5) begin
         return UART_BASE + word_addr_t'($random(seed) & 3);
      end else if (pick == 6) begin
         return word_addr_t'($random(seed) & 'hFF);   // Below both windows
      end
      return 30'h300 + word_addr_t'($random(seed) & 'hFFFF);
   endfunction

   task automatic drive_idle();
      probe_mem_i        = 1'b0;
      probe_address_i    = '0;
      probe_mem_read_i   = 1'b0;
      probe_mem_write_i  = 1'b0;
      probe_mask_byte_i  = '0;
      probe_write_data_i = '0;
      cpu_inst_type_i    = MEM_NONE;
      cpu_address_i      = '0;
      cpu_write_data_i   = '0;
   endtask

   // One probe cycle while the core tries a word load or store of its own
   task automatic probe_op();
      word_addr_t a;
      logic       rd;
      logic       wr;
      byte_mask_t mask;
      word_t      data;
      word_t      expected;
      logic       valid_addr;
      a                  = rand_address();
      rd                 = $random(seed);
      wr                 = $random(seed);
      mask               = $random(seed);
      data               = $random(seed);
      probe_mem_i        = 1'b1;
      probe_address_i    = a;
      probe_mem_read_i   = rd;
      probe_mem_write_i  = wr;
      probe_mask_byte_i  = mask;
      probe_write_data_i = data;
      cpu_inst_type_i    = ($random(seed) & 1) ? LOAD_WORD : STORE_WORD;
      cpu_address_i      = {rand_address(), 2'b00};
      cpu_write_data_i   = $random(seed);
      expected           = model_read(a);
      valid_addr         = in_mem(a) || in_uart(a);
      #2;
      check_value(invalid_address_o, (rd || wr) && !valid_addr, "invalid_address_o");
      check_value(uart_write_o, wr && in_uart(a), "uart_write_o");
      if (wr && in_uart(a)) begin
         check_value(uart_data_o, data[7:0], "uart_data_o");
      end
      if (!rd) begin
         check_value(probe_read_data_o, '0, "probe_read_data_o");
      end else if (readable(a)) begin
         check_value(probe_read_data_o, expected, "probe_read_data_o");
      end
      check_value(cpu_read_data_o, '0, "cpu_read_data_o");
      if (wr) begin
         model_write(a, mask, data);
      end
      @(posedge clk);
      #1;
   endtask

   // One core access while the idle probe drives a write
   task automatic core_op();
      mem_inst_type_t t;
      word_addr_t     a;
      logic [1:0]     off;
      word_t          data;
      word_t          aligned;
      word_t          lane;
      word_t          expected;
      byte_mask_t     base;
      byte_mask_t     mask;
      int             size;
      logic           is_load;
      logic           is_store;
      logic           misaligned;
      logic           active;
      t        = mem_inst_type_t'($unsigned($random(seed)) % 9);
      a        = rand_address();
      off      = $random(seed);
      data     = $random(seed);
      is_load  = t inside {LOAD_BYTE, LOAD_HALF, LOAD_WORD, LOAD_BYTE_U, LOAD_HALF_U};
      is_store = t inside {STORE_BYTE, STORE_HALF, STORE_WORD};
      size     = (t inside {LOAD_HALF, LOAD_HALF_U, STORE_HALF}) ? 2 :
                 (t inside {LOAD_WORD, STORE_WORD}) ? 4 : 1;
      misaligned = (size == 2 && off[0]) || (size == 4 && off != 2'd0);
      active     = (is_load || is_store) && !misaligned;
      base       = (size == 4) ? 4'b1111 : ((size == 2) ? 4'b0011 : 4'b0001);
      mask       = base << off;
      aligned    = data << (8*off);
      lane       = model_read(a) >> (8*off);
      case (t)
         LOAD_BYTE:   expected = {{24{lane[7]}}, lane[7:0]};
         LOAD_BYTE_U: expected = {24'h0, lane[7:0]};
         LOAD_HALF:   expected = {{16{lane[15]}}, lane[15:0]};
         LOAD_HALF_U: expected = {16'h0, lane[15:0]};
         LOAD_WORD:   expected = lane;
         default:     expected = '0;
      endcase
      if (misaligned) begin
         expected = '0;
      end

      probe_mem_i        = 1'b0;
      probe_address_i    = rand_address();
      probe_mem_read_i   = 1'b1;
      probe_mem_write_i  = 1'b1;
      probe_mask_byte_i  = 4'hF;
      probe_write_data_i = $random(seed);
      cpu_inst_type_i    = t;
      cpu_address_i      = {a, off};
      cpu_write_data_i   = data;
      #2;
      check_value(cpu_exception_o, misaligned, "cpu_exception_o");
      check_value(invalid_address_o, active && !in_mem(a) && !in_uart(a), "invalid_address_o");
      check_value(uart_write_o, is_store && !misaligned && in_uart(a), "uart_write_o");
      if (is_store && !misaligned && in_uart(a)) begin
         check_value(uart_data_o, aligned[7:0], "uart_data_o");
      end
      if (!active || !is_load || readable(a)) begin
         check_value(cpu_read_data_o, expected, "cpu_read_data_o");
      end
      check_value(probe_read_data_o, '0, "probe_read_data_o");
      if (is_store && !misaligned) begin
         model_write(a, mask, aligned);
      end
      @(posedge clk);
      #1;
   endtask

   initial begin
      int wait_cycles;
      drive_idle();
      for (int i = 0; i < MEM_WORDS; i++) begin
         model_valid[i] = '0;
      end
      model_last_byte = '0;
      model_count     = '0;

      wait_cycles = 0;
      while (reset_i !== 1'b0) begin
         @(posedge clk);
         wait_cycles++;
         if (wait_cycles > 50) begin
            $display("Timeout: reset was still high after 50 clock cycles");
            report_failure();
         end
      end
      #1;

      repeat (NUM_OPS) begin
         if ($random(seed) & 1) begin
            probe_op();
         end else begin
            core_op();
         end
      end
      drive_idle();
      @(posedge clk);
      #1;

      if (mem_subsystem_top_inst.u_bus_control.u_assertions.failures == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("Bound assertions reported %0d failures",
                  mem_subsystem_top_inst.u_bus_control.u_assertions.failures);
         report_failure();
      end
   end

endmodule

/* flist.f */
logic/memory_bus_pkg.sv
logic/memory_bus_if.sv
logic/load_store_unit.sv
logic/bus_control.sv
logic/data_memory.sv
logic/uart_port.sv
logic/mem_subsystem_top.sv
dv/mem_subsystem_assertions.sv
dv/mem_subsystem_tb.sv
